// ==== csr_commit_pkg.sv ====
/*
 * Types and constants shared by the dual-retire commit stage.
 * Only fflags, mscratch, mepc, mcause and minstret are mapped.
 * Other CSR addresses read as zero and drop writes.
 * No privilege levels, interrupts, vector state or debug mode.
 */
`default_nettype none

package csr_commit_pkg;

    // Commit queue geometry
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);  // Count must reach QUEUE_DEPTH

    // CSR map
    localparam logic [11:0] CSR_FFLAGS   = 12'h001;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MINSTRET = 12'hB02;

    localparam logic [3:0] CAUSE_ECALL = 4'd11;  // Environment call from M-mode

    // Instruction kinds seen at commit
    typedef enum logic [3:0] {
        OP_ALU    = 4'd0,
        OP_FPU    = 4'd1,
        OP_CSRRW  = 4'd2,
        OP_CSRRS  = 4'd3,
        OP_CSRRC  = 4'd4,
        OP_CSRRWI = 4'd5,
        OP_CSRRSI = 4'd6,
        OP_CSRRCI = 4'd7,
        OP_ECALL  = 4'd8,
        OP_MRET   = 4'd9
    } op_t;

    // Commands to the register file
    typedef enum logic [2:0] {
        CMD_NOPE  = 3'd0,   // Idle
        CMD_READ  = 3'd1,
        CMD_WRITE = 3'd2,   // Write, no read-back needed
        CMD_RW    = 3'd3,
        CMD_SET   = 3'd4,
        CMD_CLEAR = 3'd5,
        CMD_SYS   = 3'd6    // Trap, ECALL or MRET
    } csr_cmd_t;

    // One entry of the commit queue
    typedef struct packed {
        logic        valid;
        op_t         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] csr_addr;
        logic [63:0] data;      // Operand or result from execute
        logic [63:0] pc;
        logic [4:0]  fflags;
        logic        xcpt;      // Exception raised earlier in the pipe
        logic [3:0]  cause;
    } commit_instr_t;

endpackage

`default_nettype wire

// ==== csr_req_if.sv ====
/*
 * CSR request from the commit decoder to the register file.
 * cmd at CMD_NOPE means no CSR action this cycle; retire_cnt and
 * fflags_acc still apply every cycle.
 * rsp_busy flows back and stalls instructions that need a response.
 */
`default_nettype none

interface csr_req_if ();
    import csr_commit_pkg::*;

    csr_cmd_t    cmd;
    logic [11:0] addr;
    logic [63:0] wdata;
    op_t         op;
    logic [63:0] pc;
    logic        xcpt;
    logic [3:0]  cause;
    logic [1:0]  retire_cnt;   // Instructions counted by minstret
    logic [4:0]  fflags_acc;   // OR of retired FPU flags
    logic        rsp_busy;     // Response path full

    modport source (
        output cmd, addr, wdata, op, pc, xcpt, cause, retire_cnt, fflags_acc,
        input  rsp_busy
    );

    modport sink (
        input  cmd, addr, wdata, op, pc, xcpt, cause, retire_cnt, fflags_acc,
        output rsp_busy
    );

endinterface

`default_nettype wire

// ==== commit_queue.sv ====
/*
 * Four-entry commit queue, one push and up to two pops per cycle.
 * in_ready_o looks at the occupancy before this cycle's pops, so a
 * full queue refuses input even while it retires.
 * Slot 1 of head_o is only valid when slot 0 is.
 */
`default_nettype none

module commit_queue (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                in_valid_i,
    input  csr_commit_pkg::op_t                 in_op_i,
    input  logic [4:0]                          in_rd_i,
    input  logic [4:0]                          in_rs1_i,
    input  logic [11:0]                         in_csr_addr_i,
    input  logic [63:0]                         in_data_i,
    input  logic [63:0]                         in_pc_i,
    input  logic [4:0]                          in_fflags_i,
    input  logic                                in_xcpt_i,
    input  logic [3:0]                          in_cause_i,
    output logic                                in_ready_o,
    input  logic [1:0]                          retire_i,
    output csr_commit_pkg::commit_instr_t [1:0] head_o
);
    import csr_commit_pkg::*;

    commit_instr_t     mem_q [QUEUE_DEPTH];
    commit_instr_t     in_entry;
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_p1;
    logic [QCNT_W-1:0] count_q;
    logic              push;
    logic [1:0]        pop_cnt;

    assign in_ready_o = (count_q < QCNT_W'(QUEUE_DEPTH));
    assign push       = in_valid_i && in_ready_o;
    assign pop_cnt    = {1'b0, retire_i[0]} + {1'b0, retire_i[1]};
    assign rd_ptr_p1  = rd_ptr_q + 1'b1;   // Wraps with the pointer width

    always_comb begin
        in_entry.valid    = 1'b1;
        in_entry.op       = in_op_i;
        in_entry.rd       = in_rd_i;
        in_entry.rs1      = in_rs1_i;
        in_entry.csr_addr = in_csr_addr_i;
        in_entry.data     = in_data_i;
        in_entry.pc       = in_pc_i;
        in_entry.fflags   = in_fflags_i;
        in_entry.xcpt     = in_xcpt_i;
        in_entry.cause    = in_cause_i;
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_entry;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            rd_ptr_q <= rd_ptr_q + QPTR_W'(pop_cnt);
            count_q  <= count_q + QCNT_W'(push) - QCNT_W'(pop_cnt);
        end
    end

    // Valid bits come from the count, stored entries carry stale flags
    always_comb begin
        head_o[0]       = mem_q[rd_ptr_q];
        head_o[0].valid = (count_q != '0);
        head_o[1]       = mem_q[rd_ptr_p1];
        head_o[1].valid = (count_q > QCNT_W'(1));
    end

    // The decoder never retires an entry the queue does not hold
    a_pop_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        QCNT_W'(pop_cnt) <= count_q);

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (count_q == QCNT_W'(QUEUE_DEPTH)) |-> !push);

endmodule

`default_nettype wire

// ==== csr_interface.sv ====
/*
 * Commit decoder: picks 0, 1 or 2 retirements from the queue head
 * and builds the CSR request from slot 0. Purely combinational.
 * Slot 1 only retires next to a plain slot 0, and only as ALU/FPU.
 * Anything needing a response waits at slot 0 while rsp_busy is high.
 */
`default_nettype none

module csr_interface (
    input  csr_commit_pkg::commit_instr_t [1:0] head_i,
    output logic [1:0]                          retire_o,
    csr_req_if.source                           req
);
    import csr_commit_pkg::*;

    commit_instr_t slot0;
    commit_instr_t slot1;
    csr_cmd_t      cmd_int;
    logic [63:0]   wdata_int;
    logic          needs_rsp0;   // Slot 0 produces a response
    logic          trap0;
    logic          slot1_plain;
    logic          retire0;
    logic          retire1;
    logic [4:0]    fflags0;
    logic [4:0]    fflags1;

    assign slot0 = head_i[0];
    assign slot1 = head_i[1];

    // Command decode of the oldest entry
    always_comb begin
        cmd_int = CMD_NOPE;
        case (slot0.op)
            OP_CSRRW, OP_CSRRWI: begin
                cmd_int = (slot0.rd == 5'd0) ? CMD_WRITE : CMD_RW;
            end
            OP_CSRRS, OP_CSRRSI: begin
                cmd_int = (slot0.rs1 == 5'd0) ? CMD_READ : CMD_SET;
            end
            OP_CSRRC, OP_CSRRCI: begin
                cmd_int = (slot0.rs1 == 5'd0) ? CMD_READ : CMD_CLEAR;
            end
            OP_ECALL, OP_MRET: begin
                cmd_int = CMD_SYS;
            end
            default: begin
                cmd_int = CMD_NOPE;        // ALU and FPU need no CSR
            end
        endcase
        if (slot0.xcpt) begin
            cmd_int = CMD_SYS;             // Pending exception wins over the op
        end
    end

    // Immediate forms carry the zero-extended uimm in rs1
    always_comb begin
        if (slot0.op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) begin
            wdata_int = {59'b0, slot0.rs1};
        end else begin
            wdata_int = slot0.data;
        end
    end

    assign needs_rsp0  = (cmd_int != CMD_NOPE);
    assign trap0       = slot0.xcpt || (slot0.op == OP_ECALL);
    assign slot1_plain = slot1.valid && !slot1.xcpt &&
                         ((slot1.op == OP_ALU) || (slot1.op == OP_FPU));

    assign retire0 = slot0.valid && !(needs_rsp0 && req.rsp_busy);
    assign retire1 = retire0 && !needs_rsp0 && slot1_plain;  // Slot 0 plain too

    always_comb begin
        retire_o = {retire1, retire0};
        // Popping slot 1 alone would reorder the program
        a_retire_order: assert (retire_o != 2'b10);
    end

    // Request towards the register file
    assign req.cmd   = retire0 ? cmd_int : CMD_NOPE;
    assign req.addr  = slot0.csr_addr;
    assign req.wdata = wdata_int;
    assign req.op    = slot0.op;
    assign req.pc    = slot0.pc;
    assign req.xcpt  = retire0 && slot0.xcpt;
    assign req.cause = slot0.cause;

    // Traps leave minstret alone, 01 for one retired and 10 for two
    assign req.retire_cnt = (retire0 && !trap0) ? {retire1, !retire1} : 2'b00;

    assign fflags0 = (retire0 && (slot0.op == OP_FPU) && !slot0.xcpt) ? slot0.fflags : 5'b0;
    assign fflags1 = (retire1 && (slot1.op == OP_FPU)) ? slot1.fflags : 5'b0;
    assign req.fflags_acc = fflags0 | fflags1;

endmodule

`default_nettype wire

// ==== csr_regfile.sv ====
/*
 * CSR register file with a two-stage response path.
 * CSR state and the response are captured on the retire edge; the
 * response reaches rsp_valid_o one cycle later and holds until taken.
 * A CSR write to minstret or fflags overrides that cycle's count/flags.
 */
`default_nettype none

module csr_regfile (
    input  logic        clk_i,
    input  logic        arst_n_i,
    csr_req_if.sink     req,
    input  logic        rsp_ready_i,
    output logic        rsp_valid_o,
    output logic [63:0] rsp_data_o,
    output logic        rsp_trap_o,
    output logic [63:0] rsp_pc_o
);
    import csr_commit_pkg::*;

    logic [4:0]  fflags_q;
    logic [63:0] mscratch_q;
    logic [63:0] mepc_q;
    logic [63:0] mcause_q;
    logic [63:0] minstret_q;
    logic [63:0] old_val;
    logic [63:0] new_val;
    logic [63:0] trap_cause;
    logic [63:0] rsp_next;
    logic        csr_we;
    logic        take_trap;
    logic        is_mret;
    logic        pend_valid_q;   // Response captured, not yet at the port
    logic [63:0] pend_data_q;
    logic        pend_trap_q;
    logic [63:0] pend_pc_q;
    logic        pend_move;

    always_comb begin
        case (req.addr)
            CSR_FFLAGS:   old_val = {59'b0, fflags_q};
            CSR_MSCRATCH: old_val = mscratch_q;
            CSR_MEPC:     old_val = mepc_q;
            CSR_MCAUSE:   old_val = mcause_q;
            CSR_MINSTRET: old_val = minstret_q;
            default:      old_val = 64'b0;   // Unmapped
        endcase
    end

    always_comb begin
        case (req.cmd)
            CMD_WRITE, CMD_RW: new_val = req.wdata;
            CMD_SET:           new_val = old_val | req.wdata;
            CMD_CLEAR:         new_val = old_val & ~req.wdata;
            default:           new_val = old_val;
        endcase
    end

    assign csr_we     = req.cmd inside {CMD_WRITE, CMD_RW, CMD_SET, CMD_CLEAR};
    assign take_trap  = (req.cmd == CMD_SYS) && (req.xcpt || (req.op == OP_ECALL));
    assign is_mret    = (req.cmd == CMD_SYS) && !take_trap && (req.op == OP_MRET);
    assign trap_cause = {60'b0, (req.xcpt ? req.cause : CAUSE_ECALL)};

    always_comb begin
        if (take_trap) begin
            rsp_next = trap_cause;      // New mcause
        end else if (is_mret) begin
            rsp_next = mepc_q;
        end else begin
            rsp_next = old_val;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fflags_q   <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (csr_we && (req.addr == CSR_FFLAGS)) begin
                fflags_q <= new_val[4:0];
            end else begin
                fflags_q <= fflags_q | req.fflags_acc;
            end
            if (csr_we && (req.addr == CSR_MSCRATCH)) begin
                mscratch_q <= new_val;
            end
            if (take_trap) begin
                mepc_q   <= req.pc;
                mcause_q <= trap_cause;
            end else begin
                if (csr_we && (req.addr == CSR_MEPC)) begin
                    mepc_q <= new_val;
                end
                if (csr_we && (req.addr == CSR_MCAUSE)) begin
                    mcause_q <= new_val;
                end
            end
            if (csr_we && (req.addr == CSR_MINSTRET)) begin
                minstret_q <= new_val;     // Writer itself is not counted
            end else begin
                minstret_q <= minstret_q + 64'(req.retire_cnt);
            end
        end
    end

    // Response path
    assign pend_move    = pend_valid_q && (!rsp_valid_o || rsp_ready_i);
    assign req.rsp_busy = pend_valid_q && rsp_valid_o && !rsp_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_valid_q <= 1'b0;
            rsp_valid_o  <= 1'b0;
        end else begin
            if (req.cmd != CMD_NOPE) begin
                pend_valid_q <= 1'b1;
            end else if (pend_move) begin
                pend_valid_q <= 1'b0;
            end
            if (pend_move) begin
                rsp_valid_o <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.cmd != CMD_NOPE) begin
            pend_data_q <= rsp_next;
            pend_trap_q <= take_trap;
            pend_pc_q   <= req.pc;
        end
        if (pend_move) begin
            rsp_data_o <= pend_data_q;
            rsp_trap_o <= pend_trap_q;
            rsp_pc_o   <= pend_pc_q;
        end
    end

    // Decoder must hold requests while both response stages are full
    a_no_cmd_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req.rsp_busy |-> (req.cmd == CMD_NOPE));

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=>
            (rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_trap_o) && $stable(rsp_pc_o)));

endmodule

`default_nettype wire

// ==== csr_commit_top.sv ====
/*
 * Dual-retire commit stage: queue, commit decoder, CSR file.
 * Input to response takes 2 cycles when idle, more under back-pressure.
 * Responses come out in program order, one per CSR op, trap or MRET.
 */
`default_nettype none

module csr_commit_top (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    input  csr_commit_pkg::op_t in_op_i,
    input  logic [4:0]          in_rd_i,
    input  logic [4:0]          in_rs1_i,
    input  logic [11:0]         in_csr_addr_i,
    input  logic [63:0]         in_data_i,
    input  logic [63:0]         in_pc_i,
    input  logic [4:0]          in_fflags_i,
    input  logic                in_xcpt_i,
    input  logic [3:0]          in_cause_i,
    output logic                in_ready_o,
    output logic                rsp_valid_o,
    output logic [63:0]         rsp_data_o,
    output logic                rsp_trap_o,
    output logic [63:0]         rsp_pc_o,
    input  logic                rsp_ready_i
);
    import csr_commit_pkg::*;

    commit_instr_t [1:0] head;     // Two oldest queue entries
    logic [1:0]          retire;

    csr_req_if req_if ();

    commit_queue u_queue (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .in_rd_i       (in_rd_i),
        .in_rs1_i      (in_rs1_i),
        .in_csr_addr_i (in_csr_addr_i),
        .in_data_i     (in_data_i),
        .in_pc_i       (in_pc_i),
        .in_fflags_i   (in_fflags_i),
        .in_xcpt_i     (in_xcpt_i),
        .in_cause_i    (in_cause_i),
        .in_ready_o    (in_ready_o),
        .retire_i      (retire),
        .head_o        (head)
    );

    csr_interface u_csr_if (
        .head_i   (head),
        .retire_o (retire),
        .req      (req_if.source)
    );

    csr_regfile u_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req         (req_if.sink),
        .rsp_ready_i (rsp_ready_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_trap_o  (rsp_trap_o),
        .rsp_pc_o    (rsp_pc_o)
    );

endmodule

`default_nettype wire

// ==== tb_csr_commit_top.sv ====
/*
 * Testbench for the dual-retire commit stage.
 * Random instructions come from a fixed-seed LCG and are checked against
 * an in-order CSR model. Outputs are sampled on the falling clock edge.
 * The run stops at the first error and is bounded by a cycle counter.
 */
`default_nettype none

module tb_csr_commit_top;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_commit_pkg::*;

    localparam int          NUM_INSTR      = 600;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 8;
    localparam logic [11:0] CSR_UNMAPPED   = 12'h7C0;

    logic        clk_i;
    logic        arst_n_i;
    logic        in_valid_i;
    op_t         in_op_i;
    logic [4:0]  in_rd_i;
    logic [4:0]  in_rs1_i;
    logic [11:0] in_csr_addr_i;
    logic [63:0] in_data_i;
    logic [63:0] in_pc_i;
    logic [4:0]  in_fflags_i;
    logic        in_xcpt_i;
    logic [3:0]  in_cause_i;
    logic        in_ready_o;
    logic        rsp_valid_o;
    logic [63:0] rsp_data_o;
    logic        rsp_trap_o;
    logic [63:0] rsp_pc_o;
    logic        rsp_ready_i;

    logic [31:0] stim_seed  = 32'hb8c8_fb60;
    logic [31:0] ready_seed = 32'hb8c8_fb60 ^ 32'h5a5a_5a5a;  // Separate stream for ready
    logic [1:0]  ready_mode = 2'd2;    // 0 random, 1 low, 2 high
    logic [63:0] next_pc    = 64'h8000_0000;
    int          cycle_cnt  = 0;
    logic        saw_full   = 1'b0;

    // Reference CSR state
    logic [4:0]  m_fflags   = '0;
    logic [63:0] m_mscratch = '0;
    logic [63:0] m_mepc     = '0;
    logic [63:0] m_mcause   = '0;
    logic [63:0] m_minstret = '0;

    logic [63:0] exp_data [$];
    logic        exp_trap [$];
    logic [63:0] exp_pc   [$];

    logic        hold_pending = 1'b0;
    logic [63:0] held_data;
    logic        held_trap;
    logic [63:0] held_pc;

    csr_commit_top u_dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .in_rd_i       (in_rd_i),
        .in_rs1_i      (in_rs1_i),
        .in_csr_addr_i (in_csr_addr_i),
        .in_data_i     (in_data_i),
        .in_pc_i       (in_pc_i),
        .in_fflags_i   (in_fflags_i),
        .in_xcpt_i     (in_xcpt_i),
        .in_cause_i    (in_cause_i),
        .in_ready_o    (in_ready_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o),
        .rsp_trap_o    (rsp_trap_o),
        .rsp_pc_o      (rsp_pc_o),
        .rsp_ready_i   (rsp_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] rand16();
        stim_seed = lcg_next(stim_seed);
        return stim_seed[31:16];        // Upper bits are the better ones
    endfunction

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [63:0] csr_read(input logic [11:0] addr);
        case (addr)
            CSR_FFLAGS:   return {59'b0, m_fflags};
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MINSTRET: return m_minstret;
            default:      return 64'b0;
        endcase
    endfunction

    task automatic csr_write(input logic [11:0] addr, input logic [63:0] val);
        case (addr)
            CSR_FFLAGS:   m_fflags   = val[4:0];
            CSR_MSCRATCH: m_mscratch = val;
            CSR_MEPC:     m_mepc     = val;
            CSR_MCAUSE:   m_mcause   = val;
            CSR_MINSTRET: m_minstret = val;
            default:      ;                 // Unmapped address drops the write
        endcase
    endtask

    task automatic push_exp(input logic [63:0] data, input logic trap, input logic [63:0] pc);
        exp_data.push_back(data);
        exp_trap.push_back(trap);
        exp_pc.push_back(pc);
    endtask

    // Applies the accepted instruction to the model in program order
    task automatic model_accept();
        logic [63:0] src;
        logic [63:0] old;
        logic [63:0] nval;
        logic        wr;
        if (in_xcpt_i) begin
            m_mepc   = in_pc_i;
            m_mcause = {60'b0, in_cause_i};
            push_exp(m_mcause, 1'b1, in_pc_i);
        end else begin
            case (in_op_i)
                OP_ALU: m_minstret = m_minstret + 64'd1;
                OP_FPU: begin
                    m_minstret = m_minstret + 64'd1;
                    m_fflags   = m_fflags | in_fflags_i;
                end
                OP_ECALL: begin
                    m_mepc   = in_pc_i;
                    m_mcause = {60'b0, CAUSE_ECALL};
                    push_exp(m_mcause, 1'b1, in_pc_i);
                end
                OP_MRET: begin
                    push_exp(m_mepc, 1'b0, in_pc_i);
                    m_minstret = m_minstret + 64'd1;
                end
                default: begin
                    if (in_op_i inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) begin
                        src = {59'b0, in_rs1_i};
                    end else begin
                        src = in_data_i;
                    end
                    old = csr_read(in_csr_addr_i);
                    wr  = (in_op_i inside {OP_CSRRW, OP_CSRRWI}) || (in_rs1_i != 5'd0);
                    case (in_op_i)
                        OP_CSRRS, OP_CSRRSI: nval = old | src;
                        OP_CSRRC, OP_CSRRCI: nval = old & ~src;
                        default:             nval = src;
                    endcase
                    push_exp(old, 1'b0, in_pc_i);
                    if (wr) begin
                        csr_write(in_csr_addr_i, nval);
                    end
                    if (!(wr && (in_csr_addr_i == CSR_MINSTRET))) begin
                        m_minstret = m_minstret + 64'd1;   // Writer of minstret not counted
                    end
                end
            endcase
        end
    endtask

    // Handshakes are decided at the falling edge where all signals are settled
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (hold_pending) begin
                check_value("rsp_valid_o held", 64'(rsp_valid_o), 64'd1);
                check_value("rsp_data_o held", rsp_data_o, held_data);
                check_value("rsp_trap_o held", 64'(rsp_trap_o), 64'(held_trap));
                check_value("rsp_pc_o held", rsp_pc_o, held_pc);
            end
            hold_pending = rsp_valid_o && !rsp_ready_i;
            held_data    = rsp_data_o;
            held_trap    = rsp_trap_o;
            held_pc      = rsp_pc_o;
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_data.size() == 0) begin
                    $display("Unexpected response at %0t with nothing outstanding", $time);
                    fail_run();
                end else begin
                    check_value("rsp_data_o", rsp_data_o, exp_data.pop_front());
                    check_value("rsp_trap_o", 64'(rsp_trap_o), 64'(exp_trap.pop_front()));
                    check_value("rsp_pc_o", rsp_pc_o, exp_pc.pop_front());
                end
            end
            if (!in_ready_o) begin
                saw_full = 1'b1;
            end
            if (in_valid_i && in_ready_o) begin
                model_accept();
            end
        end
    end

    always @(posedge clk_i) begin
        ready_seed = lcg_next(ready_seed);
        case (ready_mode)
            2'd1:    rsp_ready_i <= 1'b0;
            2'd2:    rsp_ready_i <= 1'b1;
            default: rsp_ready_i <= (ready_seed[31:16] % 16'd10) < 16'd7;  // About 70 %
        endcase
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    // Called on a rising edge and returns on the edge of the handshake
    task automatic drive_instr(input op_t op, input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [11:0] addr, input logic [63:0] data,
                               input logic [4:0] ff, input logic xc, input logic [3:0] cause);
        in_valid_i    <= 1'b1;
        in_op_i       <= op;
        in_rd_i       <= rd;
        in_rs1_i      <= rs1;
        in_csr_addr_i <= addr;
        in_data_i     <= data;
        in_pc_i       <= next_pc;
        in_fflags_i   <= ff;
        in_xcpt_i     <= xc;
        in_cause_i    <= cause;
        next_pc = next_pc + 64'd4;
        @(negedge clk_i);
        while (!in_ready_o) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    function automatic op_t pick_op(input logic [3:0] k);
        case (k)
            4'd0, 4'd1, 4'd2, 4'd3: return OP_ALU;
            4'd4, 4'd5, 4'd6:       return OP_FPU;
            4'd7:  return OP_CSRRW;
            4'd9:  return OP_CSRRC;
            4'd10: return OP_CSRRWI;
            4'd11: return OP_CSRRSI;
            4'd12: return OP_CSRRCI;
            4'd13: return OP_ECALL;
            4'd14: return OP_MRET;
            default: return OP_CSRRS;
        endcase
    endfunction

    function automatic logic [11:0] pick_addr(input logic [2:0] k);
        case (k)
            3'd0:    return CSR_FFLAGS;
            3'd1:    return CSR_MSCRATCH;
            3'd2:    return CSR_MEPC;
            3'd3:    return CSR_MCAUSE;
            3'd4:    return CSR_MINSTRET;
            default: return CSR_UNMAPPED;
        endcase
    endfunction

    task automatic send_random();
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        logic [63:0] data;
        r1 = rand16();
        r2 = rand16();
        r3 = rand16();
        data[15:0]  = rand16();
        data[31:16] = rand16();
        data[47:32] = rand16();
        data[63:48] = rand16();
        drive_instr(pick_op(r1[15:12]),
                    (r2[15:13] == 3'd0) ? 5'd0 : r2[4:0],
                    (r2[12:11] == 2'd0) ? 5'd0 : r2[9:5],
                    pick_addr(3'(r1[11:0] % 12'd6)),
                    data, r3[4:0], r3[15:12] == 4'd0, r3[8:5]);
        if (r3[11:10] == 2'd0) begin
            in_valid_i <= 1'b0;         // Idle gap on the input port
            repeat (1 + int'(r3[9])) @(posedge clk_i);
        end
    endtask

    // Single read into an idle design expecting rsp_valid_o 2 cycles after the handshake
    task automatic measure_latency();
        int n;
        n = 0;
        @(posedge clk_i);
        drive_instr(OP_CSRRS, 5'd3, 5'd0, CSR_MSCRATCH, 64'd0, 5'd0, 1'b0, 4'd0);
        in_valid_i <= 1'b0;
        do begin
            @(posedge clk_i);
            n++;
            @(negedge clk_i);
        end while (!rsp_valid_o && (n < 8));
        check_value("rsp_valid_o latency", 64'(n), 64'd2);
    endtask

    // Responses held back so that CSR writes pile up until the queue is full
    task automatic fill_queue();
        ready_mode = 2'd1;
        repeat (2) @(posedge clk_i);
        for (int i = 0; i < 6; i++) begin
            drive_instr(OP_CSRRW, 5'd1, 5'd0, CSR_MSCRATCH,
                        64'(i + 1) * 64'h0101_0101_0101_0101, 5'd0, 1'b0, 4'd0);
        end
        in_valid_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        if (!saw_full) begin
            $display("in_ready_o never went low while responses were held back");
            fail_run();
        end
        @(negedge clk_i);
        ready_mode = 2'd0;
    endtask

    initial begin
        arst_n_i      = 1'b0;
        in_valid_i    = 1'b0;
        in_op_i       = OP_ALU;
        in_rd_i       = '0;
        in_rs1_i      = '0;
        in_csr_addr_i = '0;
        in_data_i     = '0;
        in_pc_i       = '0;
        in_fflags_i   = '0;
        in_xcpt_i     = 1'b0;
        in_cause_i    = '0;
        rsp_ready_i   = 1'b0;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("rsp_valid_o after reset", 64'(rsp_valid_o), 64'd0);
        check_value("in_ready_o after reset", 64'(in_ready_o), 64'd1);
        measure_latency();
        fill_queue();
        @(posedge clk_i);
        for (int i = 0; i < NUM_INSTR; i++) begin
            send_random();
        end
        drive_instr(OP_CSRRS, 5'd1, 5'd0, CSR_MINSTRET, 64'd0, 5'd0, 1'b0, 4'd0);
        drive_instr(OP_CSRRS, 5'd2, 5'd0, CSR_FFLAGS, 64'd0, 5'd0, 1'b0, 4'd0);
        in_valid_i <= 1'b0;
        while (exp_data.size() != 0) @(posedge clk_i);
        repeat (10) @(posedge clk_i);   // Any late extra response fails in the monitor
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_commit_top.f ====
csr_commit_pkg.sv
csr_req_if.sv
commit_queue.sv
csr_interface.sv
csr_regfile.sv
csr_commit_top.sv
tb_csr_commit_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the commit stage testbench with Verilator.
# The run passes only if the simulation log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_commit_top \
    -f csr_commit_top.f > build.log 2>&1 &&
./obj_dir/Vtb_csr_commit_top > sim.log 2>&1 ||
echo "Build or simulation failed, see build.log and sim.log"
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
